// ==== verilog/beam_tx_pkg.sv ====
package beam_tx_pkg;

    // Input and counter widths
    localparam int R_W     = 8;
    localparam int POINT_W = 13;

    // Integer delay in samples, squares need twice that
    localparam int DELAY_W = 14;
    localparam int SQ_W    = 2 * DELAY_W;

    typedef logic [R_W-1:0]     r_t;
    typedef logic [DELAY_W-1:0] delay_t;
    typedef logic [SQ_W-1:0]    sq_t;
    typedef logic [POINT_W-1:0] point_t;

    // Scanline control
    typedef enum logic [1:0] {
        IDLE,
        SEED,
        WAIT_TX
    } seed_state_t;

    // Delay search per element offset
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_STEP,   // One N increment per cycle
        GEN_EMIT    // Delay for offset k is final
    } gen_state_t;

endpackage

// ==== verilog/focal_seed.sv ====
`timescale 1ns/1ps

module focal_seed #(
    parameter int R_STEP = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                initiate,
    input  beam_tx_pkg::r_t     r_0,
    input  beam_tx_pkg::point_t num_points,
    input  logic                tx_done,
    output logic                seed_valid,
    output beam_tx_pkg::delay_t n0,
    output logic                done
);
    import beam_tx_pkg::*;

    // Radius can grow past r_0 by up to num_points steps
    localparam int RAD_W  = POINT_W + 1;
    localparam int PROD_W = RAD_W + 11;

    seed_state_t       state;
    point_t            point_cnt;
    point_t            num_points_q;
    logic [RAD_W-1:0]  radius;
    logic [PROD_W-1:0] prod;
    logic              last_point;

    // 1039 * r = 1024r + 16r - r, then divide by 64
    assign prod = (PROD_W'(radius) << 10) + (PROD_W'(radius) << 4) - PROD_W'(radius);
    assign n0   = prod[6 +: DELAY_W];

    assign last_point = (point_cnt == num_points_q - 1'b1);
    assign done       = (state == WAIT_TX) && tx_done && last_point;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            seed_valid <= 1'b0;
            point_cnt  <= '0;
        end else begin
            seed_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (initiate && num_points != '0) begin
                        point_cnt  <= '0;
                        seed_valid <= 1'b1;
                        state      <= SEED;
                    end
                end
                SEED: begin
                    state <= WAIT_TX;
                end
                WAIT_TX: begin
                    if (tx_done) begin
                        if (last_point) begin
                            state <= IDLE;
                        end else begin
                            point_cnt  <= point_cnt + 1'b1;
                            seed_valid <= 1'b1;
                            state      <= SEED;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Scanline operands, only loaded from IDLE so a busy initiate is dropped
    always_ff @(posedge clk) begin
        if (state == IDLE && initiate) begin
            num_points_q <= num_points;
            radius       <= RAD_W'(r_0);
        end else if (state == WAIT_TX && tx_done && !last_point) begin
            radius <= radius + RAD_W'(R_STEP);
        end
    end

    // The seed strobe and the state register stay in lockstep
    a_seed_in_seed: assert property (@(posedge clk) disable iff (rst)
        seed_valid |-> state == SEED);

endmodule

// ==== verilog/element_delay_gen.sv ====
`timescale 1ns/1ps

module element_delay_gen #(
    parameter int  NUM_ELEMENTS  = 64,
    parameter int  ELEMENT_PITCH = 3,
    localparam int IDX_W         = $clog2(NUM_ELEMENTS / 2 + 1)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                seed_valid,
    input  beam_tx_pkg::delay_t n0,
    output logic                elem_valid,
    output logic [IDX_W-1:0]    elem_offset,
    output beam_tx_pkg::delay_t elem_delay,
    output logic                elem_last
);
    import beam_tx_pkg::*;

    localparam int  HALF     = NUM_ELEMENTS / 2;
    localparam sq_t PITCH_SQ = sq_t'(ELEMENT_PITCH * ELEMENT_PITCH);

    gen_state_t       state;
    delay_t           n;            // Candidate delay
    sq_t              n_sq;         // Running N squared
    sq_t              n_sq_inc;
    sq_t              seed_sq;
    sq_t              target;       // N0^2 + (k * pitch)^2
    sq_t              target_next;
    sq_t              off_inc;      // (2k + 1) * pitch^2
    logic [IDX_W-1:0] k;
    delay_t           prev_delay;   // Delay emitted for the previous offset

    assign seed_sq     = sq_t'(n0) * sq_t'(n0);
    assign n_sq_inc    = n_sq + sq_t'({n, 1'b1});   // (N+1)^2 = N^2 + 2N + 1
    assign target_next = target + off_inc;

    assign elem_valid  = (state == GEN_EMIT);
    assign elem_offset = k;
    assign elem_delay  = n;
    assign elem_last   = elem_valid && (k == IDX_W'(HALF));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GEN_IDLE;
            k     <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    // Centre element needs no search
                    if (seed_valid) begin
                        k     <= '0;
                        state <= GEN_EMIT;
                    end
                end
                GEN_STEP: begin
                    if (n_sq_inc >= target) begin
                        state <= GEN_EMIT;
                    end
                end
                GEN_EMIT: begin
                    if (elem_last) begin
                        state <= GEN_IDLE;
                    end else begin
                        k <= k + 1'b1;
                        // Current N may already cover the next offset
                        if (n_sq < target_next) begin
                            state <= GEN_STEP;
                        end
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == GEN_IDLE && seed_valid) begin
            n       <= n0;
            n_sq    <= seed_sq;
            target  <= seed_sq;
            off_inc <= PITCH_SQ;
        end else if (state == GEN_STEP) begin
            n    <= n + 1'b1;
            n_sq <= n_sq_inc;
        end else if (state == GEN_EMIT) begin
            target  <= target_next;
            off_inc <= off_inc + (PITCH_SQ << 1);
        end
    end

    always_ff @(posedge clk) begin
        if (elem_valid) begin
            prev_delay <= elem_delay;
        end
    end

    // Delays grow with distance from the centre element
    a_delay_monotonic: assert property (@(posedge clk) disable iff (rst)
        elem_valid && elem_offset != '0 |-> elem_delay >= prev_delay);

endmodule

// ==== verilog/delay_table.sv ====
`timescale 1ns/1ps

module delay_table #(
    parameter int  NUM_ELEMENTS = 64,
    localparam int IDX_W        = $clog2(NUM_ELEMENTS / 2 + 1)
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          elem_valid,
    input  logic [IDX_W-1:0]                              elem_offset,
    input  beam_tx_pkg::delay_t                           elem_delay,
    input  logic                                          elem_last,
    output logic                                          table_ready,
    output logic [NUM_ELEMENTS*beam_tx_pkg::DELAY_W-1:0]  delay_flat,
    output beam_tx_pkg::delay_t                           delay_min,
    output beam_tx_pkg::delay_t                           delay_max
);
    import beam_tx_pkg::*;

    localparam int HALF   = NUM_ELEMENTS / 2;
    localparam int ADDR_W = $clog2(NUM_ELEMENTS);

    delay_t            mem [NUM_ELEMENTS];
    logic [ADDR_W-1:0] pos_idx;
    logic [ADDR_W-1:0] neg_idx;
    logic              has_neg;

    // Centre element sits at HALF-1, one side has one more element
    assign pos_idx = ADDR_W'(HALF - 1) + ADDR_W'(elem_offset);
    assign neg_idx = ADDR_W'(HALF - 1) - ADDR_W'(elem_offset);
    assign has_neg = (elem_offset != '0) && (elem_offset < IDX_W'(HALF));

    always_ff @(posedge clk) begin
        if (elem_valid) begin
            mem[pos_idx] <= elem_delay;
            if (has_neg) begin
                mem[neg_idx] <= elem_delay;     // Mirror slot
            end
        end
    end

    // Offset 0 opens a new point
    always_ff @(posedge clk) begin
        if (elem_valid) begin
            if (elem_offset == '0) begin
                delay_min <= elem_delay;
                delay_max <= elem_delay;
            end else begin
                if (elem_delay < delay_min) begin
                    delay_min <= elem_delay;
                end
                if (elem_delay > delay_max) begin
                    delay_max <= elem_delay;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            table_ready <= 1'b0;
        end else begin
            table_ready <= elem_valid && elem_last;
        end
    end

    for (genvar i = 0; i < NUM_ELEMENTS; i++) begin : g_flat
        assign delay_flat[i*DELAY_W +: DELAY_W] = mem[i];
    end

    a_offset_range: assert property (@(posedge clk) disable iff (rst)
        elem_valid |-> elem_offset <= IDX_W'(HALF));

endmodule

// ==== verilog/tx_countdown.sv ====
`timescale 1ns/1ps

module tx_countdown #(
    parameter int NUM_ELEMENTS = 64
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          table_ready,
    input  logic [NUM_ELEMENTS*beam_tx_pkg::DELAY_W-1:0]  delay_flat,
    input  beam_tx_pkg::delay_t                           delay_min,
    input  beam_tx_pkg::delay_t                           delay_max,
    output logic [NUM_ELEMENTS-1:0]                       tx_array,
    output logic                                          tx_done
);
    import beam_tx_pkg::*;

    logic                    running;
    delay_t                  cnt;
    delay_t                  span;      // Last count value
    delay_t                  max_q;
    logic [NUM_ELEMENTS-1:0] hit;

    // Longest delay fires first
    for (genvar i = 0; i < NUM_ELEMENTS; i++) begin : g_hit
        assign hit[i] = (cnt == max_q - delay_flat[i*DELAY_W +: DELAY_W]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            cnt      <= '0;
            tx_array <= '0;
            tx_done  <= 1'b0;
        end else begin
            tx_array <= running ? hit : '0;
            tx_done  <= running && (cnt == span);
            if (table_ready) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                if (cnt == span) begin
                    running <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (table_ready) begin
            span  <= delay_max - delay_min;
            max_q <= delay_max;
        end
    end

    // Next table only lands once the previous countdown is over and quiet
    a_quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
        table_ready |-> !running && tx_array == '0);

endmodule

// ==== verilog/beam_tx_top.sv ====
`timescale 1ns/1ps

module beam_tx_top #(
    parameter int  NUM_ELEMENTS  = 64,     // Even
    parameter int  ELEMENT_PITCH = 3,
    parameter int  R_STEP        = 1,
    localparam int IDX_W         = $clog2(NUM_ELEMENTS / 2 + 1)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    initiate,
    input  beam_tx_pkg::r_t         r_0,
    input  beam_tx_pkg::point_t     num_points,
    output logic [NUM_ELEMENTS-1:0] tx_array,
    output logic                    done
);
    import beam_tx_pkg::*;

    logic                          seed_valid;
    delay_t                        n0;
    logic                          elem_valid;
    logic [IDX_W-1:0]              elem_offset;
    delay_t                        elem_delay;
    logic                          elem_last;
    logic                          table_ready;
    logic [NUM_ELEMENTS*DELAY_W-1:0] delay_flat;
    delay_t                        delay_min;
    delay_t                        delay_max;
    logic                          tx_done;

    focal_seed #(
        .R_STEP (R_STEP)
    ) u_seed (
        .clk        (clk),
        .rst        (rst),
        .initiate   (initiate),
        .r_0        (r_0),
        .num_points (num_points),
        .tx_done    (tx_done),
        .seed_valid (seed_valid),
        .n0         (n0),
        .done       (done)
    );

    element_delay_gen #(
        .NUM_ELEMENTS  (NUM_ELEMENTS),
        .ELEMENT_PITCH (ELEMENT_PITCH)
    ) u_gen (
        .clk         (clk),
        .rst         (rst),
        .seed_valid  (seed_valid),
        .n0          (n0),
        .elem_valid  (elem_valid),
        .elem_offset (elem_offset),
        .elem_delay  (elem_delay),
        .elem_last   (elem_last)
    );

    delay_table #(
        .NUM_ELEMENTS (NUM_ELEMENTS)
    ) u_table (
        .clk         (clk),
        .rst         (rst),
        .elem_valid  (elem_valid),
        .elem_offset (elem_offset),
        .elem_delay  (elem_delay),
        .elem_last   (elem_last),
        .table_ready (table_ready),
        .delay_flat  (delay_flat),
        .delay_min   (delay_min),
        .delay_max   (delay_max)
    );

    tx_countdown #(
        .NUM_ELEMENTS (NUM_ELEMENTS)
    ) u_countdown (
        .clk         (clk),
        .rst         (rst),
        .table_ready (table_ready),
        .delay_flat  (delay_flat),
        .delay_min   (delay_min),
        .delay_max   (delay_max),
        .tx_array    (tx_array),
        .tx_done     (tx_done)
    );

endmodule

// ==== dv/beam_tx_model.svh ====
`ifndef BEAM_TX_MODEL_SVH
`define BEAM_TX_MODEL_SVH

// Centre element delay, floor(1039 * r / 64)
function automatic int centre_delay(input int radius);
    return (1039 * radius) / 64;
endfunction

// Smallest N with N^2 >= n0^2 + (k * pitch)^2
function automatic int element_delay(input int n0, input int k);
    longint target;
    longint n;
    target = longint'(n0) * n0 + longint'(k * ELEMENT_PITCH) * (k * ELEMENT_PITCH);
    n = $rtoi($sqrt(real'(target)));
    while (n * n < target) begin
        n++;
    end
    while (n > 0 && (n - 1) * (n - 1) >= target) begin
        n--;
    end
    return int'(n);
endfunction

// Fills the expected delays and firing offsets for one scan point
function automatic void build_point(input int radius);
    int k;
    exp_n0  = centre_delay(radius);
    exp_min = exp_n0;
    exp_max = exp_n0;
    for (int i = 0; i < NUM_ELEMENTS; i++) begin
        k = (i >= HALF - 1) ? i - (HALF - 1) : (HALF - 1) - i;
        exp_delay[i] = element_delay(exp_n0, k);
        if (exp_delay[i] < exp_min) begin
            exp_min = exp_delay[i];
        end
        if (exp_delay[i] > exp_max) begin
            exp_max = exp_delay[i];
        end
    end
    for (int i = 0; i < NUM_ELEMENTS; i++) begin
        exp_offset[i] = exp_max - exp_delay[i];     // Longest delay fires first
    end
endfunction

`endif

// ==== dv/beam_tx_tb.sv ====
`timescale 1ns/1ps

module beam_tx_tb;
    import beam_tx_pkg::*;

    localparam int NUM_ELEMENTS  = 64;
    localparam int ELEMENT_PITCH = 3;
    localparam int R_STEP        = 1;
    localparam int HALF          = NUM_ELEMENTS / 2;
    localparam int NUM_ROWS      = 6;

    typedef struct packed {
        logic [7:0]  r0;
        logic [12:0] points;
        logic        rand_r;    // r0 comes from the seeded generator
        logic        mid_init;  // Extra initiate while busy
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    initiate;
    r_t                      r_0;
    point_t                  num_points;
    logic [NUM_ELEMENTS-1:0] tx_array;
    logic                    done;

    row_t rows [NUM_ROWS] = '{
        '{8'd0,   13'd1, 1'b0, 1'b0},
        '{8'd10,  13'd3, 1'b0, 1'b1},
        '{8'd0,   13'd2, 1'b1, 1'b0},
        '{8'd200, 13'd2, 1'b0, 1'b0},
        '{8'd0,   13'd3, 1'b1, 1'b0},
        '{8'd255, 13'd2, 1'b0, 1'b0}
    };

    int seed = 32'h513b;
    int errors;
    int checks;
    int cycle;
    int cycle_limit;
    int done_count;
    int fire_count [NUM_ELEMENTS];
    int fire_cycle [NUM_ELEMENTS];
    logic [NUM_ELEMENTS-1:0] tx_prev;
    logic done_prev;

    // Model results for the current point
    int exp_n0;
    int exp_min;
    int exp_max;
    int exp_delay  [NUM_ELEMENTS];
    int exp_offset [NUM_ELEMENTS];

    `include "beam_tx_model.svh"

    always #10 clk = ~clk;

    beam_tx_top #(
        .NUM_ELEMENTS  (NUM_ELEMENTS),
        .ELEMENT_PITCH (ELEMENT_PITCH),
        .R_STEP        (R_STEP)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .initiate   (initiate),
        .r_0        (r_0),
        .num_points (num_points),
        .tx_array   (tx_array),
        .done       (done)
    );

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
                 $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Records every transmit pulse, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                if (tx_array[i]) begin
                    if (tx_prev[i]) begin
                        report_problem($sformatf("tx_array[%0d] stayed high for two cycles", i));
                    end
                    fire_count[i]++;
                    fire_cycle[i] = cycle;
                end
            end
            if (done) begin
                if (done_prev) begin
                    report_problem("done stayed high for two cycles");
                end
                done_count++;
            end
        end
        tx_prev   = tx_array;
        done_prev = done;
    end

    task automatic clear_fires();
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            fire_count[i] = 0;
            fire_cycle[i] = 0;
        end
    endtask

    function automatic bit all_fired();
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            if (fire_count[i] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic start_scan(input r_t r, input point_t n);
        @(posedge clk);
        #1;
        initiate   = 1'b1;
        r_0        = r;
        num_points = n;
        @(posedge clk);
        #1;
        initiate   = 1'b0;
    endtask

    // Offsets are taken from the first pulse of the point
    task automatic check_point(input int p, input int last);
        int first;
        first = fire_cycle[0];
        for (int i = 1; i < NUM_ELEMENTS; i++) begin
            if (fire_cycle[i] < first) begin
                first = fire_cycle[i];
            end
        end
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            checks += 2;
            if (fire_count[i] != 1) begin
                report_mismatch($sformatf("tx_array[%0d] pulse count", i), 1, fire_count[i]);
            end
            if (fire_cycle[i] - first != exp_offset[i]) begin
                report_mismatch($sformatf("tx_array[%0d] offset, point %0d", i, p),
                                exp_offset[i], fire_cycle[i] - first);
            end
        end
        checks++;
        if (done_count != ((p == last) ? 1 : 0)) begin
            report_mismatch($sformatf("done count after point %0d", p),
                            (p == last) ? 1 : 0, done_count);
        end
    endtask

    task automatic check_quiet(input int n_cycles);
        repeat (n_cycles) begin
            @(negedge clk);
            checks++;
            if (tx_array != '0) begin
                report_mismatch("tx_array while idle", 0, tx_array);
            end
            if (done) begin
                report_mismatch("done while idle", 0, 1);
            end
        end
    endtask

    initial begin
        int row_errors;
        int longest;
        int rnd;
        rst        = 1'b1;
        initiate   = 1'b0;
        r_0        = '0;
        num_points = '0;
        errors     = 0;
        checks     = 0;
        done_count = 0;
        cycle_limit = 400;  // Reset and slack
        clear_fires();

        // Random radii first, then the cycle budget from the model
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rand_r) begin
                rnd = $random(seed);
                rows[i].r0 = rnd[7:0];
            end
            longest = 0;
            for (int p = 0; p < int'(rows[i].points); p++) begin
                build_point(int'(rows[i].r0) + p * R_STEP);
                // Search steps, emits, then the countdown
                if ((exp_max - exp_n0) + HALF + 6 + (exp_max - exp_min) + 3 > longest) begin
                    longest = (exp_max - exp_n0) + HALF + 6 + (exp_max - exp_min) + 3;
                end
            end
            cycle_limit += int'(rows[i].points) * longest + 60;
        end

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_quiet(5);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row_errors = errors;
            done_count = 0;
            clear_fires();
            start_scan(rows[i].r0, rows[i].points);
            for (int p = 0; p < int'(rows[i].points); p++) begin
                build_point(int'(rows[i].r0) + p * R_STEP);
                while (!all_fired()) begin
                    @(posedge clk);
                end
                check_point(p, int'(rows[i].points) - 1);
                clear_fires();
                if (rows[i].mid_init && p == 0) begin
                    start_scan(~rows[i].r0, 13'd1);  // Must be ignored
                end
            end
            check_quiet(20);
            checks++;
            if (done_count != 1) begin
                report_mismatch("done pulses per scanline", 1, done_count);
            end
            $display("row %0d r_0=%0d points=%0d: %0d errors", i, rows[i].r0,
                     rows[i].points, errors - row_errors);
        end

        $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle = 0;
        @(posedge clk);
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+dv
verilog/beam_tx_pkg.sv
verilog/focal_seed.sv
verilog/element_delay_gen.sv
verilog/delay_table.sv
verilog/tx_countdown.sv
verilog/beam_tx_top.sv
dv/beam_tx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the beamformer testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module beam_tx_tb -o sim_beam_tx; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_beam_tx > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi
exit 0
